/* flist.f */
+incdir+src
src/mini_mcu_pkg.sv
src/system_bus.sv
src/obi_sram.sv
src/peripheral_subsystem.sv
src/mini_mcu.sv
tests/tb_mini_mcu.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the mini MCU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_mini_mcu -o sim_mini_mcu

out=$(./obj_dir/sim_mini_mcu 2>&1) || true
echo "$out"

if grep -qF '*** PASSED ***' <<< "$out"; then
  exit 0
fi
exit 1

/* src/mini_mcu.sv */
// ==============================
// mini MCU top: two master ports on a shared bus
// with two RAM banks and the peripheral block
// ==============================

`timescale 1ns/1ps

`include "mini_mcu_config.svh"

module mini_mcu (
  input  logic                   clk_i,
  input  logic                   arst_n_i,

  input  mini_mcu_pkg::bus_req_t core_req_i,
  output mini_mcu_pkg::bus_rsp_t core_rsp_o,
  input  mini_mcu_pkg::bus_req_t dbg_req_i,
  output mini_mcu_pkg::bus_rsp_t dbg_rsp_o,

  output logic                   exit_valid_o,
  output logic [31:0]            exit_value_o
);

  import mini_mcu_pkg::*;

  // half the memory per bank, four bytes per word
  localparam int RAM_WORDS = `MEM_BYTES / 8;

  bus_req_t ram0_req;
  bus_rsp_t ram0_rsp;
  bus_req_t ram1_req;
  bus_rsp_t ram1_rsp;
  bus_req_t periph_req;
  bus_rsp_t periph_rsp;

  system_bus u_system_bus (
    .clk_i        ( clk_i      ),
    .arst_n_i     ( arst_n_i   ),
    .core_req_i   ( core_req_i ),
    .core_rsp_o   ( core_rsp_o ),
    .dbg_req_i    ( dbg_req_i  ),
    .dbg_rsp_o    ( dbg_rsp_o  ),
    .ram0_req_o   ( ram0_req   ),
    .ram0_rsp_i   ( ram0_rsp   ),
    .ram1_req_o   ( ram1_req   ),
    .ram1_rsp_i   ( ram1_rsp   ),
    .periph_req_o ( periph_req ),
    .periph_rsp_i ( periph_rsp )
  );

  obi_sram #(
    .NUM_WORDS ( RAM_WORDS )
  ) u_ram0 (
    .clk_i    ( clk_i    ),
    .arst_n_i ( arst_n_i ),
    .req_i    ( ram0_req ),
    .rsp_o    ( ram0_rsp )
  );

  obi_sram #(
    .NUM_WORDS ( RAM_WORDS )
  ) u_ram1 (
    .clk_i    ( clk_i    ),
    .arst_n_i ( arst_n_i ),
    .req_i    ( ram1_req ),
    .rsp_o    ( ram1_rsp )
  );

  peripheral_subsystem u_peripheral_subsystem (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .req_i        ( periph_req   ),
    .rsp_o        ( periph_rsp   ),
    .exit_valid_o ( exit_valid_o ),
    .exit_value_o ( exit_value_o )
  );

endmodule

/* src/mini_mcu_config.svh */
// ==============================
// address map and memory sizing for the mini MCU
// include wherever the map is decoded
// ==============================

`ifndef MINI_MCU_CONFIG_SVH
`define MINI_MCU_CONFIG_SVH

// total RAM in bytes, split over two banks
`define MEM_BYTES 8192
`define RAM_BANK_BYTES (`MEM_BYTES / 2)

`define RAM0_BASE 32'h0000_0000
`define RAM1_BASE (`RAM0_BASE + `RAM_BANK_BYTES)

// peripheral window, 4 KiB
`define PERIPH_BASE  32'h2000_0000
`define PERIPH_BYTES 32'h0000_1000

`define PERIPH_ID 32'h4d43_0001

// returned for reads outside every window
`define UNMAPPED_RDATA 32'hdead_beef

`endif

/* src/mini_mcu_pkg.sv */
// ==============================
// shared bus types for the mini MCU interconnect
// request/response pair and slave select encoding
// ==============================

package mini_mcu_pkg;

  // master to slave, held until gnt
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } bus_req_t;

  // slave to master, rvalid one cycle after gnt
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } bus_rsp_t;

  typedef enum logic [1:0] {
    SLV_RAM0   = 2'd0,
    SLV_RAM1   = 2'd1,
    SLV_PERIPH = 2'd2,
    SLV_NONE   = 2'd3
  } slave_sel_e;

  // byte-lane merge of a write into an existing word
  function automatic logic [31:0] be_merge(input logic [31:0] old_word,
                                           input logic [31:0] new_word,
                                           input logic [3:0]  be);
    logic [31:0] merged;
    merged = old_word;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        merged[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return merged;
  endfunction

endpackage

/* src/obi_sram.sv */
// ==============================
// word RAM bank behind a bus slave port
// always grants, answers one cycle later
// ==============================

`timescale 1ns/1ps

module obi_sram #(
  parameter int NUM_WORDS = 1024
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  mini_mcu_pkg::bus_req_t req_i,
  output mini_mcu_pkg::bus_rsp_t rsp_o
);

  import mini_mcu_pkg::*;

  localparam int AW = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1;

  logic [31:0]   mem [NUM_WORDS];
  logic [AW-1:0] idx;
  logic [31:0]   rdata_q;
  logic          rvalid_q;

  // byte address in, word index out
  assign idx = req_i.addr[AW+1:2];

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= mem[idx];
      if (req_i.we) begin
        mem[idx] <= be_merge(mem[idx], req_i.wdata, req_i.be);
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  assign rsp_o.gnt    = 1'b1;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;

endmodule

/* src/peripheral_subsystem.sv */
// ==============================
// peripheral registers: ID, two scratch words, exit
// a write to exit flags the end of the program
// ==============================

`timescale 1ns/1ps

`include "mini_mcu_config.svh"

module peripheral_subsystem (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  mini_mcu_pkg::bus_req_t req_i,
  output mini_mcu_pkg::bus_rsp_t rsp_o,
  output logic                   exit_valid_o,
  output logic [31:0]            exit_value_o
);

  import mini_mcu_pkg::*;

  localparam logic [11:0] OFF_ID       = 12'h000;
  localparam logic [11:0] OFF_SCRATCH0 = 12'h004;
  localparam logic [11:0] OFF_SCRATCH1 = 12'h008;
  localparam logic [11:0] OFF_EXIT     = 12'h00c;

  logic [11:0] offset;
  logic        wr_en;
  logic [31:0] scratch0_q;
  logic [31:0] scratch1_q;
  logic        exit_valid_q;
  logic [31:0] exit_value_q;
  logic [31:0] rd_data;
  logic [31:0] rdata_q;
  logic        rvalid_q;

  assign offset = req_i.addr[11:0];
  assign wr_en  = req_i.req && req_i.we;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      scratch0_q   <= '0;
      scratch1_q   <= '0;
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
      rvalid_q     <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
      if (wr_en) begin
        case (offset)
          OFF_SCRATCH0: scratch0_q <= be_merge(scratch0_q, req_i.wdata, req_i.be);
          OFF_SCRATCH1: scratch1_q <= be_merge(scratch1_q, req_i.wdata, req_i.be);
          OFF_EXIT: begin
            exit_value_q <= req_i.wdata;
            // sticky until reset
            exit_valid_q <= 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (offset)
      OFF_ID:       rd_data = `PERIPH_ID;
      OFF_SCRATCH0: rd_data = scratch0_q;
      OFF_SCRATCH1: rd_data = scratch1_q;
      OFF_EXIT:     rd_data = exit_value_q;
      default:      rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= rd_data;
    end
  end

  assign rsp_o.gnt    = 1'b1;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule

/* src/system_bus.sv */
// ==============================
// system bus for two masters with round-robin grant
// decodes RAM0, RAM1 and peripheral windows
// ==============================

`timescale 1ns/1ps

`include "mini_mcu_config.svh"

module system_bus (
  input  logic                   clk_i,
  input  logic                   arst_n_i,

  input  mini_mcu_pkg::bus_req_t core_req_i,
  output mini_mcu_pkg::bus_rsp_t core_rsp_o,
  input  mini_mcu_pkg::bus_req_t dbg_req_i,
  output mini_mcu_pkg::bus_rsp_t dbg_rsp_o,

  output mini_mcu_pkg::bus_req_t ram0_req_o,
  input  mini_mcu_pkg::bus_rsp_t ram0_rsp_i,
  output mini_mcu_pkg::bus_req_t ram1_req_o,
  input  mini_mcu_pkg::bus_rsp_t ram1_rsp_i,
  output mini_mcu_pkg::bus_req_t periph_req_o,
  input  mini_mcu_pkg::bus_rsp_t periph_rsp_i
);

  import mini_mcu_pkg::*;

  // set when debug wins the next contested cycle
  logic        rr_dbg_q;
  logic        win_dbg;
  logic        contested;
  logic        granted;
  logic        slv_gnt;
  bus_req_t    win_req;
  bus_req_t    slv_req;
  slave_sel_e  sel_d;
  slave_sel_e  sel_q;
  logic        mst_dbg_q;
  logic        pend_q;
  logic [31:0] ram0_off;
  logic [31:0] ram1_off;
  logic [31:0] periph_off;
  logic        rsp_valid;
  logic [31:0] rsp_rdata;

  // arbitration
  assign contested = core_req_i.req && dbg_req_i.req;
  assign win_dbg   = dbg_req_i.req && (!core_req_i.req || rr_dbg_q);
  assign win_req   = win_dbg ? dbg_req_i : core_req_i;

  // offsets double as the rebased slave address
  assign ram0_off   = win_req.addr - `RAM0_BASE;
  assign ram1_off   = win_req.addr - `RAM1_BASE;
  assign periph_off = win_req.addr - `PERIPH_BASE;

  always_comb begin
    if (ram0_off < `RAM_BANK_BYTES) begin
      sel_d = SLV_RAM0;
    end else if (ram1_off < `RAM_BANK_BYTES) begin
      sel_d = SLV_RAM1;
    end else if (periph_off < `PERIPH_BYTES) begin
      sel_d = SLV_PERIPH;
    end else begin
      sel_d = SLV_NONE;
    end
  end

  // only the selected slave sees the request
  always_comb begin
    slv_req      = win_req;
    ram0_req_o   = '0;
    ram1_req_o   = '0;
    periph_req_o = '0;
    slv_gnt      = 1'b1;
    case (sel_d)
      SLV_RAM0: begin
        slv_req.addr = ram0_off;
        ram0_req_o   = slv_req;
        slv_gnt      = ram0_rsp_i.gnt;
      end
      SLV_RAM1: begin
        slv_req.addr = ram1_off;
        ram1_req_o   = slv_req;
        slv_gnt      = ram1_rsp_i.gnt;
      end
      SLV_PERIPH: begin
        slv_req.addr = periph_off;
        periph_req_o = slv_req;
        slv_gnt      = periph_rsp_i.gnt;
      end
      // unmapped, the bus accepts and drops it
      default: slv_gnt = 1'b1;
    endcase
  end

  assign granted = win_req.req && slv_gnt;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_dbg_q  <= 1'b0;
      pend_q    <= 1'b0;
      mst_dbg_q <= 1'b0;
      sel_q     <= SLV_NONE;
    end else begin
      pend_q <= granted;
      if (granted) begin
        sel_q     <= sel_d;
        mst_dbg_q <= win_dbg;
      end
      if (granted && contested) begin
        rr_dbg_q <= !rr_dbg_q;
      end
    end
  end

  // response from whichever slave was granted last cycle
  always_comb begin
    case (sel_q)
      SLV_RAM0: begin
        rsp_valid = ram0_rsp_i.rvalid;
        rsp_rdata = ram0_rsp_i.rdata;
      end
      SLV_RAM1: begin
        rsp_valid = ram1_rsp_i.rvalid;
        rsp_rdata = ram1_rsp_i.rdata;
      end
      SLV_PERIPH: begin
        rsp_valid = periph_rsp_i.rvalid;
        rsp_rdata = periph_rsp_i.rdata;
      end
      default: begin
        rsp_valid = 1'b1;
        rsp_rdata = `UNMAPPED_RDATA;
      end
    endcase
  end

  always_comb begin
    core_rsp_o     = '0;
    dbg_rsp_o      = '0;
    core_rsp_o.gnt = granted && !win_dbg;
    dbg_rsp_o.gnt  = granted && win_dbg;
    if (pend_q && rsp_valid) begin
      if (mst_dbg_q) begin
        dbg_rsp_o.rvalid = 1'b1;
        dbg_rsp_o.rdata  = rsp_rdata;
      end else begin
        core_rsp_o.rvalid = 1'b1;
        core_rsp_o.rdata  = rsp_rdata;
      end
    end
  end

endmodule

/* tests/mini_mcu_stimulus.txt */
# columns: group port(core|debug) we be addr wdata expected_rdata, all hex but group
# lines of one group go out on both ports in the same cycle; writes ignore the last column
1 core  1 f 00000000 11223344 00000000
1 debug 1 f 00001000 a5a5a5a5 00000000
2 core  0 f 00000000 00000000 11223344
2 debug 0 f 00001000 00000000 a5a5a5a5
3 core  1 3 00000000 ffffbbcc 00000000
4 debug 0 f 00000000 00000000 1122bbcc
5 debug 1 c 00001000 77660000 00000000
6 core  0 f 00001000 00000000 7766a5a5
7 core  1 f 00000ffc 0badf00d 00000000
7 debug 1 f 00001ffc 12345678 00000000
8 core  0 f 00001ffc 00000000 12345678
8 debug 0 f 00000ffc 00000000 0badf00d
9 core  0 f 00000ffc 00000000 0badf00d
9 debug 0 f 00000ffc 00000000 0badf00d
10 core  0 f 20000000 00000000 4d430001
11 core  1 f 20000004 01020304 00000000
11 debug 1 f 20000008 aabbccdd 00000000
12 debug 1 2 20000004 0000ee00 00000000
13 core  0 f 20000004 00000000 0102ee04
13 debug 0 f 20000008 00000000 aabbccdd
14 debug 1 9 20000008 11000022 00000000
15 core  0 f 20000008 00000000 11bbcc22
16 debug 0 f 20000010 00000000 00000000
16 core  0 f 20000ffc 00000000 00000000
17 core  1 f 00002000 55555555 00000000
17 debug 0 f 30000000 00000000 deadbeef
18 core  0 f 00002000 00000000 deadbeef
18 debug 0 f 00000000 00000000 1122bbcc
19 core  0 f 00001000 00000000 7766a5a5
20 core  1 f 2000000c 0000002a 00000000

/* tests/tb_mini_mcu.sv */
// ==============================
// testbench for the mini MCU that replays the stimulus file
// on the core and debug ports and checks every response
// ==============================

`timescale 1ns/1ps

`include "mini_mcu_config.svh"

module tb_mini_mcu;

  import mini_mcu_pkg::*;

  localparam int MAX_LINES = 64;
  // cycles a request may wait for gnt
  localparam int GNT_WAIT  = 4;
  localparam int ST_IDLE   = 0;
  localparam int ST_GNT    = 1;
  localparam int ST_RSP    = 2;

  logic        clk;
  logic        arst_n;
  bus_req_t    core_req;
  bus_rsp_t    core_rsp;
  bus_req_t    dbg_req;
  bus_rsp_t    dbg_rsp;
  logic        exit_valid;
  logic [31:0] exit_value;

  int          st_group [MAX_LINES];
  logic        st_dbg   [MAX_LINES];
  logic        st_we    [MAX_LINES];
  logic [3:0]  st_be    [MAX_LINES];
  logic [31:0] st_addr  [MAX_LINES];
  logic [31:0] st_wdata [MAX_LINES];
  logic [31:0] st_rdata [MAX_LINES];
  int          num_lines;

  // index 0 is the core port and 1 the debug port
  int          state     [2];
  int          line_of   [2];
  int          gnt_cycle [2];

  int          cycle_count = 0;
  int          cycle_limit = 0;
  logic [31:0] lfsr_q      = 32'heab5;

  mini_mcu u_mini_mcu (
    .clk_i        ( clk        ),
    .arst_n_i     ( arst_n     ),
    .core_req_i   ( core_req   ),
    .core_rsp_o   ( core_rsp   ),
    .dbg_req_i    ( dbg_req    ),
    .dbg_rsp_o    ( dbg_rsp    ),
    .exit_valid_o ( exit_valid ),
    .exit_value_o ( exit_value )
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      abort_run($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
    end
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("mismatch at %0t ns: %s is %h, expected %h",
                          $time, name, actual, expected));
    end
  endtask

  // fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_bits(input int n, output int value);
    int k;
    value = 0;
    for (k = 0; k < n; k++) begin
      lfsr_q = lfsr_step(lfsr_q);
      value  = (value << 1) | int'(lfsr_q[0]);
    end
  endtask

  function automatic string port_name(input int p);
    return (p == 0) ? "core_rsp_o" : "dbg_rsp_o";
  endfunction

  task automatic drive_port(input int p, input bus_req_t value);
    if (p == 0) begin
      core_req <= value;
    end else begin
      dbg_req <= value;
    end
  endtask

  task automatic read_stimulus();
    int          fd;
    int          n;
    int          grp;
    string       line;
    logic [63:0] port_tok;
    logic [31:0] we_v;
    logic [31:0] be_v;
    logic [31:0] addr_v;
    logic [31:0] wdata_v;
    logic [31:0] rdata_v;
    fd = $fopen("tests/mini_mcu_stimulus.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open tests/mini_mcu_stimulus.txt");
    end
    num_lines = 0;
    while ($fgets(line, fd) != 0) begin
      if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n") begin
        continue;
      end
      n = $sscanf(line, "%d %s %h %h %h %h %h", grp, port_tok, we_v, be_v, addr_v,
                  wdata_v, rdata_v);
      if (n != 7 || num_lines == MAX_LINES) begin
        abort_run($sformatf("stimulus line cannot be used: %s", line));
      end
      if (port_tok == {32'h0, "core"}) begin
        st_dbg[num_lines] = 1'b0;
      end else if (port_tok == {24'h0, "debug"}) begin
        st_dbg[num_lines] = 1'b1;
      end else begin
        abort_run($sformatf("unknown port in stimulus line: %s", line));
      end
      st_group[num_lines] = grp;
      st_we[num_lines]    = we_v[0];
      st_be[num_lines]    = be_v[3:0];
      st_addr[num_lines]  = addr_v;
      st_wdata[num_lines] = wdata_v;
      st_rdata[num_lines] = rdata_v;
      num_lines++;
    end
    $fclose(fd);
  endtask

  task automatic service_port(input int p, input int cyc);
    bus_rsp_t rsp;
    int       ln;
    rsp = (p == 0) ? core_rsp : dbg_rsp;
    ln  = line_of[p];
    case (state[p])
      ST_GNT: begin
        check_value($sformatf("%s.rvalid", port_name(p)), 32'(rsp.rvalid), 0);
        if (rsp.gnt) begin
          gnt_cycle[p] = cyc;
          state[p]     = ST_RSP;
        end else if (cyc >= GNT_WAIT) begin
          abort_run($sformatf("%s: request to %h was never granted", port_name(p),
                              st_addr[ln]));
        end
      end
      ST_RSP: begin
        if (!rsp.rvalid) begin
          abort_run($sformatf("%s: no rvalid in the cycle after gnt", port_name(p)));
        end
        check_value($sformatf("%s.gnt", port_name(p)), 32'(rsp.gnt), 0);
        if (!st_we[ln]) begin
          check_value($sformatf("%s.rdata", port_name(p)), rsp.rdata, st_rdata[ln]);
        end
        state[p] = ST_IDLE;
      end
      default: begin
        check_value($sformatf("%s.gnt", port_name(p)), 32'(rsp.gnt), 0);
        check_value($sformatf("%s.rvalid", port_name(p)), 32'(rsp.rvalid), 0);
      end
    endcase
  endtask

  // issue the pending lines together and serve them to completion
  task automatic run_group();
    int       cyc;
    int       p;
    logic     active [2];
    logic     both;
    bus_req_t req;
    active[0] = (state[0] == ST_GNT);
    active[1] = (state[1] == ST_GNT);
    both      = active[0] && active[1];
    @(posedge clk);
    for (p = 0; p < 2; p++) begin
      if (state[p] == ST_GNT) begin
        req = '{req: 1'b1, we: st_we[line_of[p]], be: st_be[line_of[p]],
                addr: st_addr[line_of[p]], wdata: st_wdata[line_of[p]]};
        drive_port(p, req);
      end
    end
    cyc = 0;
    while (state[0] != ST_IDLE || state[1] != ST_IDLE) begin
      @(negedge clk);
      if (cyc == 0) begin
        check_value("exit_valid_o", 32'(exit_valid), 0);
      end
      service_port(0, cyc);
      service_port(1, cyc);
      @(posedge clk);
      for (p = 0; p < 2; p++) begin
        if (state[p] != ST_GNT) begin
          drive_port(p, '0);
        end
      end
      cyc++;
    end
    if (both) begin
      // one wins at once and the other exactly one cycle later
      check_value("first gnt cycle", (gnt_cycle[0] < gnt_cycle[1]) ? gnt_cycle[0] :
                  gnt_cycle[1], 0);
      check_value("second gnt cycle", (gnt_cycle[0] < gnt_cycle[1]) ? gnt_cycle[1] :
                  gnt_cycle[0], 1);
    end else begin
      // a lone request is granted in its request cycle
      for (p = 0; p < 2; p++) begin
        if (active[p]) begin
          check_value($sformatf("%s gnt cycle", port_name(p)), gnt_cycle[p], 0);
        end
      end
    end
  endtask

  initial begin
    int i;
    int g;
    int p;
    int idle;
    int last;
    arst_n   = 1'b0;
    core_req = '0;
    dbg_req  = '0;
    state    = '{ST_IDLE, ST_IDLE};
    read_stimulus();
    if (num_lines == 0) begin
      abort_run("stimulus file holds no transactions");
    end
    last = num_lines - 1;
    if (!st_we[last] || st_addr[last] != (`PERIPH_BASE + 32'hc)) begin
      abort_run("last stimulus line does not write the exit register");
    end
    cycle_limit = num_lines * 8 + 100;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_value("exit_valid_o", 32'(exit_valid), 0);
    check_value("exit_value_o", exit_value, 0);
    i = 0;
    while (i < num_lines) begin
      g = st_group[i];
      while (i < num_lines && st_group[i] == g) begin
        p = st_dbg[i] ? 1 : 0;
        if (state[p] != ST_IDLE) begin
          abort_run($sformatf("group %0d has two lines for one port", g));
        end
        state[p]   = ST_GNT;
        line_of[p] = i;
        i++;
      end
      run_group();
      random_bits(2, idle);
      repeat (idle) @(posedge clk);
    end
    @(negedge clk);
    check_value("exit_valid_o", 32'(exit_valid), 1);
    check_value("exit_value_o", exit_value, st_wdata[last]);
    $display("*** PASSED ***");
    $finish;
  end

endmodule
